// ==== include/drv_consts.svh ====
`ifndef DRV_CONSTS_SVH
`define DRV_CONSTS_SVH

// Driver bank size, scaled down to two drivers per board group
`define DRV_NUM_DRIVERS 6
// Bits per grayscale or control write
`define DRV_WORD_BITS 48

// Column multiplexing within one slice
`define DRV_MUX_COLUMNS 8
`define DRV_WRTGS_PER_COL 10
`define DRV_BLANKING_TIME 72

// LAT command lengths, counted in SCLK slots
`define DRV_LAT_FCWRTEN 15
`define DRV_LAT_WRTFC 5
`define DRV_LAT_WRTGS 1
`define DRV_LAT_LATGS 3

// Function-control word loaded after reset
`define DRV_DEFAULT_CONF 48'h0000_3C2F_8A41

`endif

// ==== src/drv_pkg.sv ====
`include "drv_consts.svh"

package drv_pkg;

    // Sequencer phases
    typedef enum logic [2:0] {
        STALL,
        PREPARE_CONFIG,
        CONFIG,
        WRTFC_TIMING,
        WAIT_SLICE,
        BLANKING,
        PAUSE_SCLK,
        SHIFT
    } drv_phase_t;

    // Per-cycle slot state, sequencer to shift-out
    typedef struct packed {
        drv_phase_t phase;
        logic [5:0] cnt;
        logic [3:0] led;
        logic [1:0] colour;
        // Last round of a column in SHIFT, GCLK window over in WAIT_SLICE
        logic       last_word;
    } drv_slot_t;

    typedef logic [`DRV_WORD_BITS-1:0] drv_conf_t;

    // One grayscale word per lane for a shift round
    typedef logic [`DRV_NUM_DRIVERS-1:0][`DRV_WORD_BITS-1:0] drv_pixels_t;

    typedef struct packed {
        logic [23:0] rsvd;
        logic        pending;
        logic        configured;
        logic [2:0]  column;
        drv_phase_t  phase;
    } drv_status_t;

    // Wishbone classic, word addressed by byte offset
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    localparam logic [3:0] REG_CONF_LO = 4'h0;
    localparam logic [3:0] REG_CONF_HI = 4'h4;
    localparam logic [3:0] REG_CTRL    = 4'h8;
    localparam logic [3:0] REG_STATUS  = 4'hC;

    // LED order per board group, red/green then blue
    localparam logic [3:0] LUT_RG [3][16] = '{
        '{6, 7, 9, 8, 10, 11, 13, 12, 14, 15, 1, 0, 2, 3, 5, 4},
        '{2, 3, 5, 4, 6, 7, 9, 8, 10, 11, 13, 12, 14, 15, 1, 0},
        '{2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 0, 1}
    };

    localparam logic [3:0] LUT_B [3][16] = '{
        '{8, 9, 14, 15, 12, 13, 2, 3, 0, 1, 6, 7, 4, 5, 10, 11},
        '{0, 1, 6, 7, 4, 5, 9, 11, 8, 10, 14, 15, 12, 13, 2, 3},
        '{1, 0, 6, 7, 5, 4, 8, 11, 9, 10, 14, 15, 13, 12, 2, 3}
    };

endpackage

// ==== src/drv_wb_regs.sv ====
`timescale 1ns/1ps
`include "drv_consts.svh"

module drv_wb_regs (
    input  logic                 clk,
    input  logic                 nrst,
    input  drv_pkg::wb_req_t     wb_req,
    output drv_pkg::wb_rsp_t     wb_rsp,
    output drv_pkg::drv_conf_t   conf,
    output logic                 conf_commit,
    input  logic                 conf_taken,
    input  drv_pkg::drv_status_t status_in
);
    import drv_pkg::*;

    // Host-side copy, only moved to conf on commit
    drv_conf_t   conf_stage;
    logic        ack_q;
    logic [31:0] rdata_q;
    logic        pending;
    logic        access;
    logic        commit_now;
    drv_status_t status_rd;

    // New access when strobed and no ack in flight
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    assign commit_now = access && wb_req.we && wb_req.adr == REG_CTRL && wb_req.dat[0];

    assign wb_rsp = '{ack: ack_q, dat: rdata_q};

    // Pending flag lives here, the sequencer knows nothing of it
    always_comb begin
        status_rd = status_in;
        status_rd.pending = pending;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ack_q       <= 1'b0;
            conf_stage  <= `DRV_DEFAULT_CONF;
            conf        <= `DRV_DEFAULT_CONF;
            conf_commit <= 1'b0;
        end else begin
            ack_q       <= access;
            conf_commit <= commit_now;
            if (commit_now) begin
                conf <= conf_stage;
            end
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    REG_CONF_LO: conf_stage[31:0] <= wb_req.dat;
                    REG_CONF_HI: conf_stage[`DRV_WORD_BITS-1:32] <= wb_req.dat[15:0];
                    default: ;
                endcase
            end
        end
    end

    // Set by a commit, cleared once the sequencer restarts
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pending <= 1'b0;
        end else if (commit_now) begin
            pending <= 1'b1;
        end else if (conf_taken) begin
            pending <= 1'b0;
        end
    end

    // Read data lands together with ack
    always_ff @(posedge clk) begin
        if (access && !wb_req.we) begin
            case (wb_req.adr)
                REG_CONF_LO: rdata_q <= conf_stage[31:0];
                REG_CONF_HI: rdata_q <= {16'h0000, conf_stage[`DRV_WORD_BITS-1:32]};
                REG_STATUS:  rdata_q <= status_rd;
                default:     rdata_q <= '0;
            endcase
        end
    end

    // Ack is a single-cycle pulse
    a_ack_single: assert property (@(posedge clk) disable iff (!nrst)
        ack_q |=> !ack_q);

    // Each ack answers a strobe from the cycle before
    a_ack_after_stb: assert property (@(posedge clk) disable iff (!nrst)
        ack_q |-> $past(wb_req.cyc && wb_req.stb));

endmodule

// ==== src/drv_sequencer.sv ====
`timescale 1ns/1ps
`include "drv_consts.svh"

module drv_sequencer (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 position_sync,
    input  logic                 conf_commit,
    output logic                 conf_taken,
    output drv_pkg::drv_slot_t   slot,
    output logic                 driver_ready,
    output logic                 column_ready,
    output drv_pkg::drv_status_t status
);
    import drv_pkg::*;

    // GCLK cycles granted after a slice
    localparam int GCLK_WINDOW = 512;

    drv_phase_t phase;
    // Wide enough for the GCLK window
    logic [9:0] cnt;
    logic [3:0] round;
    logic [2:0] column;
    logic [3:0] led;
    logic [1:0] colour;
    logic       configured;
    logic       commit_req;
    logic       take;
    logic       last_round;
    logic       last_slot;

    assign last_round = round == 4'(`DRV_WRTGS_PER_COL - 1);
    assign last_slot  = cnt == 10'(`DRV_WORD_BITS - 1);

    // Restart allowed only once the display is running
    assign take = commit_req && (phase inside {WAIT_SLICE, BLANKING, PAUSE_SCLK, SHIFT});
    assign conf_taken = take;

    // Commit pulse may land mid-config, hold it until it can be served
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            commit_req <= 1'b0;
        end else begin
            commit_req <= conf_commit || (commit_req && !take);
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            phase      <= STALL;
            cnt        <= '0;
            round      <= '0;
            column     <= '0;
            led        <= '0;
            colour     <= '0;
            configured <= 1'b0;
        end else if (take) begin
            phase      <= PREPARE_CONFIG;
            cnt        <= '0;
            round      <= '0;
            column     <= '0;
            led        <= '0;
            colour     <= '0;
            configured <= 1'b0;
        end else begin
            case (phase)
                STALL: begin
                    phase <= PREPARE_CONFIG;
                end

                // FCWRTEN, LAT held high
                PREPARE_CONFIG: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 10'(`DRV_LAT_FCWRTEN - 1)) begin
                        phase <= CONFIG;
                        cnt   <= '0;
                    end
                end

                // One idle slot then the word, MSB first
                CONFIG: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 10'(`DRV_WORD_BITS)) begin
                        phase <= WRTFC_TIMING;
                        cnt   <= '0;
                    end
                end

                // Settling time after WRTFC
                WRTFC_TIMING: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 10'(`DRV_LAT_WRTFC)) begin
                        phase      <= WAIT_SLICE;
                        cnt        <= '0;
                        configured <= 1'b1;
                    end
                end

                WAIT_SLICE: begin
                    if (position_sync) begin
                        phase <= BLANKING;
                        cnt   <= '0;
                    end else if (cnt <= 10'(GCLK_WINDOW)) begin
                        // Stops one past the window so column_ready fires once
                        cnt <= cnt + 1'b1;
                    end
                end

                BLANKING: begin
                    round  <= '0;
                    led    <= '0;
                    colour <= '0;
                    cnt    <= cnt + 1'b1;
                    if (cnt == 10'(`DRV_BLANKING_TIME - 1)) begin
                        phase <= PAUSE_SCLK;
                        cnt   <= '0;
                    end
                end

                PAUSE_SCLK: begin
                    phase <= SHIFT;
                end

                SHIFT: begin
                    cnt <= cnt + 1'b1;
                    // Three colour bits per LED, led wraps at end of word
                    if (colour == 2'd2) begin
                        colour <= '0;
                        led    <= led + 1'b1;
                    end else begin
                        colour <= colour + 1'b1;
                    end
                    if (last_slot) begin
                        cnt <= '0;
                        if (last_round) begin
                            round  <= '0;
                            // Wraps to 0 after the last column
                            column <= column + 1'b1;
                            if (column == 3'(`DRV_MUX_COLUMNS - 1)) begin
                                phase <= WAIT_SLICE;
                            end else begin
                                phase <= BLANKING;
                            end
                        end else begin
                            round <= round + 1'b1;
                            phase <= PAUSE_SCLK;
                        end
                    end
                end

                default: begin
                    phase <= STALL;
                    cnt   <= '0;
                end
            endcase
        end
    end

    always_comb begin
        slot.phase     = phase;
        // Clamped, shift-out only looks at small counts
        slot.cnt       = (cnt > 10'd63) ? 6'd63 : cnt[5:0];
        slot.led       = led;
        slot.colour    = colour;
        slot.last_word = (phase == SHIFT && last_round)
                      || (phase == WAIT_SLICE && cnt >= 10'(GCLK_WINDOW));
    end

    assign driver_ready = phase == PAUSE_SCLK;
    assign column_ready = (phase == SHIFT && last_round && last_slot)
                       || (phase == WAIT_SLICE && cnt == 10'(GCLK_WINDOW));

    always_comb begin
        status            = '0;
        status.phase      = phase;
        status.column     = column;
        status.configured = configured;
    end

    // A column end from SHIFT leads to blanking, slice wait or restart
    a_column_end: assert property (@(posedge clk) disable iff (!nrst)
        column_ready && phase == SHIFT |=> phase inside {BLANKING, WAIT_SLICE, PREPARE_CONFIG});

    a_phase_known: assert property (@(posedge clk) disable iff (!nrst)
        !$isunknown(phase));

endmodule

// ==== src/drv_shift_out.sv ====
`timescale 1ns/1ps
`include "drv_consts.svh"

module drv_shift_out (
    input  logic                        clk,
    input  logic                        nrst,
    input  drv_pkg::drv_slot_t          slot,
    input  drv_pkg::drv_conf_t          conf,
    input  drv_pkg::drv_pixels_t        pixels,
    output logic                        driver_sclk,
    output logic                        driver_gclk,
    output logic                        driver_lat,
    output logic [`DRV_NUM_DRIVERS-1:0] drivers_sin
);
    import drv_pkg::*;

    logic lat_cmd;

    // Clock enables per phase
    always_comb begin
        driver_sclk = 1'b0;
        driver_gclk = 1'b0;
        case (slot.phase)
            // FCWRTEN is counted in SCLK edges under LAT
            PREPARE_CONFIG: driver_sclk = 1'b1;
            // Slot 0 keeps SCLK quiet after the command
            CONFIG:         driver_sclk = slot.cnt != '0;
            WAIT_SLICE:     driver_gclk = !slot.last_word;
            BLANKING:       driver_gclk = slot.cnt != '0;
            PAUSE_SCLK:     driver_gclk = 1'b1;
            SHIFT: begin
                driver_sclk = 1'b1;
                driver_gclk = 1'b1;
            end
            default: ;
        endcase
    end

    // LAT command for the current slot
    always_comb begin
        case (slot.phase)
            PREPARE_CONFIG: lat_cmd = 1'b1;
            // WRTFC over the last bits of the word
            CONFIG: lat_cmd = slot.cnt >= 6'(`DRV_WORD_BITS + 1 - `DRV_LAT_WRTFC);
            SHIFT: begin
                // LATGS closes the column, WRTGS every other round
                if (slot.last_word) begin
                    lat_cmd = slot.cnt >= 6'(`DRV_WORD_BITS - `DRV_LAT_LATGS);
                end else begin
                    lat_cmd = slot.cnt >= 6'(`DRV_WORD_BITS - `DRV_LAT_WRTGS);
                end
            end
            default: lat_cmd = 1'b0;
        endcase
    end

    // Falling edge, gives hold margin after the driver clock
    always_ff @(negedge clk or negedge nrst) begin
        if (!nrst) begin
            driver_lat <= 1'b0;
        end else begin
            driver_lat <= lat_cmd;
        end
    end

    // Serial data per lane
    always_comb begin
        logic [3:0] lut_val;
        int         bit_idx;

        lut_val     = '0;
        bit_idx     = 0;
        drivers_sin = '0;
        case (slot.phase)
            CONFIG: begin
                // Same control word on every lane
                if (slot.cnt != '0) begin
                    drivers_sin = {`DRV_NUM_DRIVERS{conf[`DRV_WORD_BITS - slot.cnt]}};
                end
            end
            SHIFT: begin
                for (int i = 0; i < `DRV_NUM_DRIVERS; i++) begin
                    // Blue on colour 0, red/green otherwise; group is lane pair
                    if (slot.colour == 2'd0) begin
                        lut_val = LUT_B[i / 2][15 - slot.led];
                    end else begin
                        lut_val = LUT_RG[i / 2][15 - slot.led];
                    end
                    bit_idx = 3 * lut_val + 2 - slot.colour;
                    drivers_sin[i] = pixels[i][bit_idx];
                end
            end
            default: ;
        endcase
    end

    // WRTFC LAT still high in the first half of WRTFC_TIMING, SCLK must stay off
    a_wrtfc_quiet: assert property (@(negedge clk) disable iff (!nrst)
        slot.phase == WRTFC_TIMING |-> !(driver_sclk && driver_lat));

endmodule

// ==== src/drv_ctrl_top.sv ====
`timescale 1ns/1ps
`include "drv_consts.svh"

module drv_ctrl_top (
    input  logic                        clk,
    input  logic                        nrst,
    input  drv_pkg::wb_req_t            wb_req,
    output drv_pkg::wb_rsp_t            wb_rsp,
    input  logic                        position_sync,
    input  drv_pkg::drv_pixels_t        pixels,
    output logic                        driver_ready,
    output logic                        column_ready,
    output logic                        driver_sclk,
    output logic                        driver_gclk,
    output logic                        driver_lat,
    output logic [`DRV_NUM_DRIVERS-1:0] drivers_sin
);
    import drv_pkg::*;

    drv_conf_t   conf;
    logic        conf_commit;
    logic        conf_taken;
    drv_slot_t   slot;
    drv_status_t status;

    // Host registers
    drv_wb_regs i_regs (
        .clk         (clk),
        .nrst        (nrst),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .conf        (conf),
        .conf_commit (conf_commit),
        .conf_taken  (conf_taken),
        .status_in   (status)
    );

    // Phase and slot timing
    drv_sequencer i_seq (
        .clk           (clk),
        .nrst          (nrst),
        .position_sync (position_sync),
        .conf_commit   (conf_commit),
        .conf_taken    (conf_taken),
        .slot          (slot),
        .driver_ready  (driver_ready),
        .column_ready  (column_ready),
        .status        (status)
    );

    // Driver pins
    drv_shift_out i_out (
        .clk         (clk),
        .nrst        (nrst),
        .slot        (slot),
        .conf        (conf),
        .pixels      (pixels),
        .driver_sclk (driver_sclk),
        .driver_gclk (driver_gclk),
        .driver_lat  (driver_lat),
        .drivers_sin (drivers_sin)
    );

endmodule

// ==== test/drv_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "drv_consts.svh"

module drv_ctrl_tb;
    import drv_pkg::*;

    localparam int GCLK_WINDOW = 512;
    localparam int ROUNDS = `DRV_MUX_COLUMNS * `DRV_WRTGS_PER_COL;
    // GCLK per column: blanking minus its first cycle, then pause plus shift per round
    localparam int GCLK_PER_COL = `DRV_BLANKING_TIME - 1
                                + `DRV_WRTGS_PER_COL * (`DRV_WORD_BITS + 1);

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_SYNC, OP_CFG} op_e;

    // Exp holds a control word or register read data
    typedef struct packed {
        op_e         op;
        logic [3:0]  addr;
        logic [31:0] data;
        drv_conf_t   exp;
    } step_t;

    logic                        clk;
    logic                        nrst;
    wb_req_t                     wb_req;
    wb_rsp_t                     wb_rsp;
    logic                        position_sync;
    drv_pixels_t                 pixels;
    logic                        driver_ready;
    logic                        column_ready;
    logic                        driver_sclk;
    logic                        driver_gclk;
    logic                        driver_lat;
    logic [`DRV_NUM_DRIVERS-1:0] drivers_sin;

    step_t steps [10];
    int    errors;
    int    checks;
    bit    timed_out;

    // Monitor results
    drv_pixels_t cfg_bits;
    drv_pixels_t gs_bits;
    drv_pixels_t gs_q [$];
    drv_pixels_t pix_q [$];
    int          lat_q [$];
    int          lat_len;
    int          gs_cnt;
    int          cfg_slots;
    int          gclk_cfg;
    int          gclk_cnt;
    int          ready_cnt;
    int          col_cnt;

    drv_ctrl_top i_dut (
        .clk           (clk),
        .nrst          (nrst),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .position_sync (position_sync),
        .pixels        (pixels),
        .driver_ready  (driver_ready),
        .column_ready  (column_ready),
        .driver_sclk   (driver_sclk),
        .driver_gclk   (driver_gclk),
        .driver_lat    (driver_lat),
        .drivers_sin   (drivers_sin)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_conf(input string name, input drv_conf_t exp, input drv_conf_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0d ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_pixels(input string name, input drv_pixels_t exp,
                                input drv_pixels_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0d ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0d ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAILED %0d ns %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic clear_monitor();
        lat_q.delete();
        gs_q.delete();
        pix_q.delete();
        lat_len   = 0;
        gs_cnt    = 0;
        cfg_slots = 0;
        gclk_cfg  = 0;
        gclk_cnt  = 0;
        ready_cnt = 0;
        col_cnt   = 0;
    endtask

    // Expected lane bits, slot k lands in bit 47-k
    function automatic drv_pixels_t remap(input drv_pixels_t pix);
        drv_pixels_t r;
        logic [3:0]  t;
        int          led;
        int          col;
        r = '0;
        for (int i = 0; i < `DRV_NUM_DRIVERS; i++) begin
            for (int k = 0; k < `DRV_WORD_BITS; k++) begin
                led = k / 3;
                col = k % 3;
                // Blue first in each LED triple
                if (col == 0) begin
                    t = LUT_B[i / 2][15 - led];
                end else begin
                    t = LUT_RG[i / 2][15 - led];
                end
                r[i][`DRV_WORD_BITS - 1 - k] = pix[i][3 * t + 2 - col];
            end
        end
        return r;
    endfunction

    // Sampled before the edge updates anything
    always @(posedge clk) begin
        if (nrst) begin
            if (driver_lat) begin
                lat_len++;
            end else if (lat_len != 0) begin
                lat_q.push_back(lat_len);
                lat_len = 0;
            end
            if (driver_gclk) begin
                gclk_cnt++;
            end
            if (driver_gclk && cfg_slots != 0) begin
                gclk_cfg++;
            end
            if (driver_ready) begin
                ready_cnt++;
            end
            if (column_ready) begin
                col_cnt++;
            end
            // SCLK alone means control word, with GCLK it is grayscale
            if (driver_sclk && !driver_gclk) begin
                cfg_slots++;
                for (int i = 0; i < `DRV_NUM_DRIVERS; i++) begin
                    cfg_bits[i] = {cfg_bits[i][`DRV_WORD_BITS-2:0], drivers_sin[i]};
                end
            end
            if (driver_sclk && driver_gclk) begin
                for (int i = 0; i < `DRV_NUM_DRIVERS; i++) begin
                    gs_bits[i] = {gs_bits[i][`DRV_WORD_BITS-2:0], drivers_sin[i]};
                end
                gs_cnt++;
                if (gs_cnt == `DRV_WORD_BITS) begin
                    gs_q.push_back(gs_bits);
                    gs_cnt = 0;
                end
            end
        end
    end

    // Pixel source, fresh words on every driver_ready
    initial begin
        drv_pixels_t fresh;
        pixels = '0;
        void'($urandom(53));
        forever begin
            @(posedge clk);
            if (nrst && driver_ready) begin
                #2;
                for (int i = 0; i < `DRV_NUM_DRIVERS; i++) begin
                    fresh[i] = {16'($urandom()), $urandom()};
                end
                pixels = fresh;
                pix_q.push_back(fresh);
            end
        end
    end

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        n    = 0;
        rdat = '0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            tick();
            n++;
        end while (!wb_rsp.ack && n < 20);
        wb_req = '0;
        if (!wb_rsp.ack) begin
            $display("Timeout: Wishbone slave gave no ack within 20 cycles");
            timed_out = 1'b1;
        end else begin
            rdat = wb_rsp.dat;
            check_count("wb_rsp.ack delay", 1, n);
            tick();
            check_count("wb_rsp.ack second cycle", 0, wb_rsp.ack);
        end
    endtask

    task automatic run_cfg(input drv_conf_t exp);
        int n;
        int g0;
        int s0;
        n = 0;
        // FCWRTEN and WRTFC runs both closed
        while (lat_q.size() < 2 && n < 200) begin
            tick();
            n++;
        end
        if (lat_q.size() < 2) begin
            $display("Timeout: control word load did not finish within 200 cycles");
            timed_out = 1'b1;
            return;
        end
        for (int i = 0; i < `DRV_NUM_DRIVERS; i++) begin
            check_conf($sformatf("drivers_sin[%0d] control word", i), exp, cfg_bits[i]);
        end
        check_count("driver_sclk slots", `DRV_LAT_FCWRTEN + `DRV_WORD_BITS, cfg_slots);
        check_count("driver_lat runs", 2, lat_q.size());
        check_count("driver_lat FCWRTEN length", `DRV_LAT_FCWRTEN, lat_q[0]);
        check_count("driver_lat WRTFC length", `DRV_LAT_WRTFC, lat_q[1]);
        check_count("driver_gclk during config", 0, gclk_cfg);
        // GCLK window marks entry to slice wait
        g0 = gclk_cnt;
        s0 = cfg_slots;
        n  = 0;
        while (gclk_cnt == g0 && n < 20) begin
            tick();
            n++;
        end
        if (gclk_cnt == g0) begin
            $display("Timeout: GCLK window did not open after configuration");
            timed_out = 1'b1;
        end else begin
            // Five settling cycles left after the LAT drop, then the first GCLK
            check_count("WRTFC_TIMING cycles before driver_gclk", 6, n);
            check_count("driver_sclk during WRTFC_TIMING", s0, cfg_slots);
        end
    endtask

    task automatic run_slice();
        int n;
        int g_end;
        n = 0;
        // Let the window from configuration run out first
        while (col_cnt == 0 && n < GCLK_WINDOW + 100) begin
            tick();
            n++;
        end
        if (col_cnt == 0) begin
            $display("Timeout: no column_ready at the end of the GCLK window");
            timed_out = 1'b1;
            return;
        end
        clear_monitor();
        position_sync = 1'b1;
        tick();
        position_sync = 1'b0;
        n = 0;
        while (col_cnt < `DRV_MUX_COLUMNS + 1 && n < 8000) begin
            tick();
            n++;
        end
        if (col_cnt < `DRV_MUX_COLUMNS + 1) begin
            $display("Timeout: slice did not complete within 8000 cycles");
            timed_out = 1'b1;
            return;
        end
        g_end = gclk_cnt;
        // Idle stretch, GCLK must stay stopped
        repeat (20) tick();
        check_count("driver_gclk after window", g_end, gclk_cnt);
        check_count("driver_gclk per slice", `DRV_MUX_COLUMNS * GCLK_PER_COL + GCLK_WINDOW, g_end);
        check_count("driver_ready pulses", ROUNDS, ready_cnt);
        check_count("column_ready pulses", `DRV_MUX_COLUMNS + 1, col_cnt);
        check_count("driver_sclk outside shift", 0, cfg_slots);
        check_count("driver_lat runs", ROUNDS, lat_q.size());
        check_count("grayscale words", ROUNDS, gs_q.size());
        check_count("pixel words", ROUNDS, pix_q.size());
        foreach (lat_q[j]) begin
            check_count($sformatf("driver_lat run %0d", j),
                        (j % `DRV_WRTGS_PER_COL == `DRV_WRTGS_PER_COL - 1)
                        ? `DRV_LAT_LATGS : `DRV_LAT_WRTGS, lat_q[j]);
        end
        for (int j = 0; j < gs_q.size() && j < pix_q.size(); j++) begin
            check_pixels($sformatf("drivers_sin word %0d", j), remap(pix_q[j]), gs_q[j]);
        end
    endtask

    initial begin
        drv_status_t idle;
        step_t       st;
        logic [31:0] rdat;
        int          err0;
        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        nrst          = 1'b0;
        wb_req        = '0;
        position_sync = 1'b0;
        clear_monitor();

        idle            = '0;
        idle.configured = 1'b1;
        idle.phase      = WAIT_SLICE;
        steps[0] = '{op: OP_CFG, addr: 4'h0, data: 32'h0, exp: `DRV_DEFAULT_CONF};
        steps[1] = '{op: OP_WR, addr: REG_CONF_LO, data: 32'h1234_5678, exp: '0};
        steps[2] = '{op: OP_WR, addr: REG_CONF_HI, data: 32'h0000_9ABC, exp: '0};
        steps[3] = '{op: OP_RD, addr: REG_CONF_LO, data: 32'h0, exp: 48'h1234_5678};
        steps[4] = '{op: OP_RD, addr: REG_CONF_HI, data: 32'h0, exp: 48'h9ABC};
        steps[5] = '{op: OP_RD, addr: REG_STATUS, data: 32'h0, exp: {16'h0, idle}};
        // Commit restarts the load with the staged word
        steps[6] = '{op: OP_WR, addr: REG_CTRL, data: 32'h1, exp: '0};
        steps[7] = '{op: OP_CFG, addr: 4'h0, data: 32'h0, exp: 48'h9ABC_1234_5678};
        steps[8] = '{op: OP_RD, addr: REG_STATUS, data: 32'h0, exp: {16'h0, idle}};
        steps[9] = '{op: OP_SYNC, addr: 4'h0, data: 32'h0, exp: '0};

        repeat (16) @(posedge clk);
        #2;
        nrst = 1'b1;

        foreach (steps[idx]) begin
            st   = steps[idx];
            err0 = errors;
            clear_monitor();
            case (st.op)
                OP_WR: wb_access(1'b1, st.addr, st.data, rdat);
                OP_RD: begin
                    wb_access(1'b0, st.addr, 32'h0, rdat);
                    if (!timed_out) begin
                        check_word($sformatf("wb_rsp.dat at %h", st.addr), st.exp[31:0], rdat);
                    end
                end
                OP_CFG: run_cfg(st.exp);
                default: run_slice();
            endcase
            $display("step %0d %s: %0d error(s)%s", idx, st.op.name(), errors - err0,
                     timed_out ? ", timed out" : "");
            if (timed_out) begin
                break;
            end
        end

        $display("Summary: %0d checks, %0d errors, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
src/drv_pkg.sv
src/drv_wb_regs.sv
src/drv_sequencer.sv
src/drv_shift_out.sv
src/drv_ctrl_top.sv
test/drv_ctrl_tb.sv
